// ==== bp_cfg_pkg.sv ====
// ====================
// predictor geometry: table, history and fetch
// target queue sizes, plus width types
// ====================
package bp_cfg_pkg;

    // two 16-bit parcels per fetch block
    localparam int unsigned INSTR_PER_FETCH = 2;
    localparam int unsigned SLOT_BITS       = $clog2(INSTR_PER_FETCH);

    // counter table, reshaped into rows of one fetch block each
    localparam int unsigned NR_ENTRIES = 64;
    localparam int unsigned NR_ROWS    = NR_ENTRIES / INSTR_PER_FETCH;
    localparam int unsigned INDEX_BITS = $clog2(NR_ROWS);
    localparam int unsigned TAG_BITS   = 8;

    // address slicing: bit 0 dropped, then slot, row and tag
    localparam int unsigned OFFSET  = 1;
    localparam int unsigned ROW_LSB = OFFSET + SLOT_BITS;
    localparam int unsigned TAG_LSB = ROW_LSB + INDEX_BITS;

    // global history, padded up to a whole number of index chunks
    localparam int unsigned GHR_LEN     = 8;
    localparam int unsigned EXT_GHR_LEN = ((GHR_LEN + INDEX_BITS - 1) / INDEX_BITS) * INDEX_BITS;

    // fetch target queue
    localparam int unsigned FTQ_DEPTH    = 4;
    localparam int unsigned FTQ_PTR_BITS = $clog2(FTQ_DEPTH);
    localparam int unsigned CNT_BITS     = 2;

    typedef logic [INDEX_BITS-1:0]      row_idx_t;
    typedef logic [TAG_BITS-1:0]        tag_t;
    typedef logic [INSTR_PER_FETCH-1:0] slot_mask_t;
    typedef logic [CNT_BITS-1:0]        bp_cnt_t;
    typedef logic [GHR_LEN-1:0]         ghr_t;

endpackage

// ==== bp_types_pkg.sv ====
// ====================
// front-end types: addresses, control-flow
// kinds and counter encodings
// ====================
package bp_types_pkg;

    // virtual fetch address
    typedef logic [31:0] vaddr_t;

    // control-flow kind of a parcel as seen by predecode
    // none marks a plain instruction or a not-taken branch
    typedef enum logic [2:0] {
        CF_NONE     = 3'd0,
        CF_BRANCH   = 3'd1,
        CF_JUMP     = 3'd2,
        CF_JUMP_REG = 3'd3,
        CF_RETURN   = 3'd4
    } cf_kind_e;

    // 2-bit saturating direction counter
    typedef logic [1:0] sat_cnt_t;

    // msb of the counter is the taken prediction
    localparam sat_cnt_t CNT_STRONG_NT = 2'b00;
    localparam sat_cnt_t CNT_WEAK_NT   = 2'b01;
    localparam sat_cnt_t CNT_WEAK_T    = 2'b10;
    localparam sat_cnt_t CNT_STRONG_T  = 2'b11;

endpackage

// ==== branch_filter.sv ====
// ====================
// branch filter: picks the branches of a fetch
// block that will resolve, and counts them
// ====================
`timescale 1ns/1ps

module branch_filter (
    input  bp_cfg_pkg::slot_mask_t                                   valid_i,
    input  bp_cfg_pkg::slot_mask_t                                   is_branch_i,
    input  bp_types_pkg::cf_kind_e [bp_cfg_pkg::INSTR_PER_FETCH-1:0] cf_kind_i,
    input  logic                                                     instr_queue_overflow_i,
    input  logic [bp_cfg_pkg::SLOT_BITS-1:0]                         push_instr_cnt_i,
    output bp_cfg_pkg::slot_mask_t                                   is_valid_branch_o,
    output bp_cfg_pkg::bp_cnt_t                                      branch_cnt_o
);

    // slots that the instruction queue did not take and will fetch again
    bp_cfg_pkg::slot_mask_t replay_mask;
    // valid slots that redirect fetch
    bp_cfg_pkg::slot_mask_t valid_taken_cf;

    // on overflow every slot from push_instr_cnt_i upward is replayed
    // e.g. cnt 1 gives mask 10, cnt 0 gives 11
    assign replay_mask = {bp_cfg_pkg::INSTR_PER_FETCH{instr_queue_overflow_i}}
                         << push_instr_cnt_i;

    always_comb begin
        for (int i = 0; i < bp_cfg_pkg::INSTR_PER_FETCH; i++) begin
            valid_taken_cf[i] = valid_i[i] && (cf_kind_i[i] != bp_types_pkg::CF_NONE);
        end
    end

    // walk the slots in program order
    always_comb begin
        logic taken_ahead;

        taken_ahead       = 1'b0;
        is_valid_branch_o = '0;
        branch_cnt_o      = '0;
        for (int i = 0; i < bp_cfg_pkg::INSTR_PER_FETCH; i++) begin
            // a branch survives unless replayed or shadowed by earlier taken flow
            is_valid_branch_o[i] = is_branch_i[i] & ~replay_mask[i] & ~taken_ahead;
            branch_cnt_o         = branch_cnt_o + bp_cfg_pkg::bp_cnt_t'(is_valid_branch_o[i]);
            // everything behind this slot is dropped
            taken_ahead          = taken_ahead | valid_taken_cf[i];
        end
    end

endmodule

// ==== ftq_fifo.sv ====
// ====================
// fetch target queue: per fetch block the table
// index, tag and number of pending branches
// ====================
`timescale 1ns/1ps

module ftq_fifo (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic                 push_i,
    input  logic                 pop_i,
    input  bp_cfg_pkg::row_idx_t idx_i,
    input  bp_cfg_pkg::tag_t     tag_i,
    input  bp_cfg_pkg::bp_cnt_t  cnt_i,
    output bp_cfg_pkg::row_idx_t idx_o,
    output bp_cfg_pkg::tag_t     tag_o,
    output bp_cfg_pkg::bp_cnt_t  cnt_o,
    output logic                 full_o,
    output logic                 empty_o
);

    // entry storage
    bp_cfg_pkg::row_idx_t idx_mem [bp_cfg_pkg::FTQ_DEPTH];
    bp_cfg_pkg::tag_t     tag_mem [bp_cfg_pkg::FTQ_DEPTH];
    bp_cfg_pkg::bp_cnt_t  cnt_mem [bp_cfg_pkg::FTQ_DEPTH];

    logic [bp_cfg_pkg::FTQ_PTR_BITS-1:0] rd_ptr_q;
    logic [bp_cfg_pkg::FTQ_PTR_BITS-1:0] wr_ptr_q;
    // one bit wider than the pointers so a full queue is representable
    logic [bp_cfg_pkg::FTQ_PTR_BITS:0]   usage_q;

    logic do_push;
    logic do_pop;

    assign full_o  = (usage_q == (bp_cfg_pkg::FTQ_PTR_BITS+1)'(bp_cfg_pkg::FTQ_DEPTH));
    assign empty_o = (usage_q == '0);

    // push is dropped when full, pop is ignored when empty
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // head entry, valid only when not empty
    assign idx_o = idx_mem[rd_ptr_q];
    assign tag_o = tag_mem[rd_ptr_q];
    assign cnt_o = cnt_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            idx_mem[wr_ptr_q] <= idx_i;
            tag_mem[wr_ptr_q] <= tag_i;
            cnt_mem[wr_ptr_q] <= cnt_i;
        end
    end

    // pointers wrap at the last entry
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            usage_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            usage_q  <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr_q == bp_cfg_pkg::FTQ_PTR_BITS'(bp_cfg_pkg::FTQ_DEPTH - 1)) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr_q == bp_cfg_pkg::FTQ_PTR_BITS'(bp_cfg_pkg::FTQ_DEPTH - 1)) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
            // simultaneous push and pop leaves the usage unchanged
            if (do_push && !do_pop) begin
                usage_q <= usage_q + 1'b1;
            end else if (do_pop && !do_push) begin
                usage_q <= usage_q - 1'b1;
            end
        end
    end

    // the table only retires entries that exist
    a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o);

    a_usage_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
        usage_q <= (bp_cfg_pkg::FTQ_PTR_BITS+1)'(bp_cfg_pkg::FTQ_DEPTH));

endmodule

// ==== bht_table.sv ====
// ====================
// branch history table: tagged 2-bit counters
// indexed by gshare, with in-order resolve update
// ====================
`timescale 1ns/1ps

module bht_table (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  logic                   flush_ftq_i,
    input  logic                   debug_mode_i,
    input  bp_types_pkg::vaddr_t   vpc_i,
    input  logic                   upd_valid_i,
    input  bp_types_pkg::vaddr_t   upd_pc_i,
    input  logic                   upd_taken_i,
    input  bp_cfg_pkg::row_idx_t   head_idx_i,
    input  bp_cfg_pkg::tag_t       head_tag_i,
    input  bp_cfg_pkg::bp_cnt_t    head_cnt_i,
    input  logic                   head_empty_i,
    output bp_cfg_pkg::row_idx_t   fetch_idx_o,
    output bp_cfg_pkg::tag_t       fetch_tag_o,
    output logic                   pop_o,
    output bp_cfg_pkg::slot_mask_t pred_valid_o,
    output bp_cfg_pkg::slot_mask_t pred_taken_o
);

    // counter and tag per slot of each row
    bp_types_pkg::sat_cnt_t cnt_q [bp_cfg_pkg::NR_ROWS][bp_cfg_pkg::INSTR_PER_FETCH];
    bp_cfg_pkg::tag_t       tag_q [bp_cfg_pkg::NR_ROWS][bp_cfg_pkg::INSTR_PER_FETCH];

    // global history, newest outcome in bit 0
    bp_cfg_pkg::ghr_t ghr_q;
    // branches of the head entry still to resolve, zero means not loaded yet
    bp_cfg_pkg::bp_cnt_t rem_q;
    bp_cfg_pkg::bp_cnt_t rem_eff;

    logic [bp_cfg_pkg::EXT_GHR_LEN-1:0] ext_ghr;

    // update side
    logic                                upd_en;
    logic [bp_cfg_pkg::SLOT_BITS-1:0]    upd_slot;
    bp_types_pkg::sat_cnt_t              upd_cnt_old;
    bp_types_pkg::sat_cnt_t              upd_cnt_new;
    logic                                upd_hit;

    // gshare index: row bits folded with every history chunk
    // short top chunk is padded with ones
    always_comb begin
        ext_ghr                            = '1;
        ext_ghr[bp_cfg_pkg::GHR_LEN-1:0]   = ghr_q;
        fetch_idx_o = vpc_i[bp_cfg_pkg::ROW_LSB +: bp_cfg_pkg::INDEX_BITS];
        for (int i = 0; i < bp_cfg_pkg::EXT_GHR_LEN; i += bp_cfg_pkg::INDEX_BITS) begin
            fetch_idx_o = fetch_idx_o ^ ext_ghr[i +: bp_cfg_pkg::INDEX_BITS];
        end
    end

    assign fetch_tag_o = vpc_i[bp_cfg_pkg::TAG_LSB +: bp_cfg_pkg::TAG_BITS];

    // both slots of the row are read in the same cycle
    always_comb begin
        for (int i = 0; i < bp_cfg_pkg::INSTR_PER_FETCH; i++) begin
            pred_valid_o[i] = (tag_q[fetch_idx_o][i] == fetch_tag_o);
            pred_taken_o[i] = cnt_q[fetch_idx_o][i][1];
        end
    end

    // debug mode freezes the predictor
    assign upd_en   = upd_valid_i & ~debug_mode_i;
    // row comes from the recorded index, slot from the pc
    assign upd_slot = upd_pc_i[bp_cfg_pkg::OFFSET +: bp_cfg_pkg::SLOT_BITS];

    assign upd_cnt_old = cnt_q[head_idx_i][upd_slot];
    assign upd_hit     = (tag_q[head_idx_i][upd_slot] == head_tag_i);

    always_comb begin
        upd_cnt_new = upd_cnt_old;
        if (!upd_hit) begin
            // new owner of the entry, start weak in the resolved direction
            upd_cnt_new = upd_taken_i ? bp_types_pkg::CNT_WEAK_T : bp_types_pkg::CNT_WEAK_NT;
        end else if (upd_taken_i) begin
            if (upd_cnt_old != bp_types_pkg::CNT_STRONG_T) begin
                upd_cnt_new = upd_cnt_old + 1'b1;
            end
        end else begin
            if (upd_cnt_old != bp_types_pkg::CNT_STRONG_NT) begin
                upd_cnt_new = upd_cnt_old - 1'b1;
            end
        end
    end

    // first update of an entry takes its count from the queue head
    assign rem_eff = (rem_q == '0) ? head_cnt_i : rem_q;
    // last pending branch of the head retires the entry
    assign pop_o   = upd_en && (rem_eff == bp_cfg_pkg::bp_cnt_t'(1));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int r = 0; r < bp_cfg_pkg::NR_ROWS; r++) begin
                for (int s = 0; s < bp_cfg_pkg::INSTR_PER_FETCH; s++) begin
                    cnt_q[r][s] <= '0;
                    tag_q[r][s] <= '0;
                end
            end
            ghr_q <= '0;
        end else if (flush_i) begin
            // tags survive, only the direction state is forgotten
            for (int r = 0; r < bp_cfg_pkg::NR_ROWS; r++) begin
                for (int s = 0; s < bp_cfg_pkg::INSTR_PER_FETCH; s++) begin
                    cnt_q[r][s] <= bp_types_pkg::CNT_WEAK_T;
                end
            end
            ghr_q <= '0;
        end else if (upd_en) begin
            cnt_q[head_idx_i][upd_slot] <= upd_cnt_new;
            tag_q[head_idx_i][upd_slot] <= head_tag_i;
            ghr_q <= {ghr_q[bp_cfg_pkg::GHR_LEN-2:0], upd_taken_i};
        end
    end

    // remaining count follows the queue, so either flush clears it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rem_q <= '0;
        end else if (flush_i || flush_ftq_i) begin
            rem_q <= '0;
        end else if (upd_en) begin
            rem_q <= rem_eff - 1'b1;
        end
    end

    // resolves come in program order, so a branch always has its record
    a_upd_has_head : assert property (@(posedge clk_i) disable iff (!rst_ni)
        upd_en |-> !head_empty_i);

endmodule

// ==== bht.sv ====
// ====================
// branch history top: filter, fetch target
// queue and counter table
// ====================
`timescale 1ns/1ps

module bht (
    input  logic                                                     clk_i,
    input  logic                                                     rst_ni,
    input  logic                                                     flush_i,
    input  logic                                                     flush_ftq_i,
    input  logic                                                     debug_mode_i,
    input  bp_types_pkg::vaddr_t                                     vpc_i,
    input  bp_cfg_pkg::slot_mask_t                                   valid_i,
    input  bp_cfg_pkg::slot_mask_t                                   is_branch_i,
    input  bp_types_pkg::cf_kind_e [bp_cfg_pkg::INSTR_PER_FETCH-1:0] cf_kind_i,
    input  logic                                                     instr_queue_overflow_i,
    input  logic [bp_cfg_pkg::SLOT_BITS-1:0]                         push_instr_cnt_i,
    input  logic                                                     upd_valid_i,
    input  bp_types_pkg::vaddr_t                                     upd_pc_i,
    input  logic                                                     upd_taken_i,
    output logic                                                     ftq_overflow_o,
    output bp_cfg_pkg::slot_mask_t                                   bht_prediction_valid_o,
    output bp_cfg_pkg::slot_mask_t                                   bht_prediction_taken_o
);

    bp_cfg_pkg::slot_mask_t is_valid_branch;
    bp_cfg_pkg::bp_cnt_t    branch_cnt;
    logic                   ftq_push;
    logic                   ftq_full;
    logic                   ftq_empty;
    logic                   ftq_pop;

    bp_cfg_pkg::row_idx_t   fetch_idx;
    bp_cfg_pkg::tag_t       fetch_tag;
    bp_cfg_pkg::row_idx_t   head_idx;
    bp_cfg_pkg::tag_t       head_tag;
    bp_cfg_pkg::bp_cnt_t    head_cnt;

    // a block is recorded only when it holds a surviving branch
    assign ftq_push       = |is_valid_branch;
    // no stall, a full queue just loses the block
    assign ftq_overflow_o = ftq_push & ftq_full;

    branch_filter i_branch_filter (
        .valid_i                ( valid_i                ),
        .is_branch_i            ( is_branch_i            ),
        .cf_kind_i              ( cf_kind_i              ),
        .instr_queue_overflow_i ( instr_queue_overflow_i ),
        .push_instr_cnt_i       ( push_instr_cnt_i       ),
        .is_valid_branch_o      ( is_valid_branch        ),
        .branch_cnt_o           ( branch_cnt             )
    );

    ftq_fifo i_ftq_fifo (
        .clk_i   ( clk_i                 ),
        .rst_ni  ( rst_ni                ),
        .flush_i ( flush_i | flush_ftq_i ),
        .push_i  ( ftq_push              ),
        .pop_i   ( ftq_pop               ),
        .idx_i   ( fetch_idx             ),
        .tag_i   ( fetch_tag             ),
        .cnt_i   ( branch_cnt            ),
        .idx_o   ( head_idx              ),
        .tag_o   ( head_tag              ),
        .cnt_o   ( head_cnt              ),
        .full_o  ( ftq_full              ),
        .empty_o ( ftq_empty             )
    );

    bht_table i_bht_table (
        .clk_i        ( clk_i                  ),
        .rst_ni       ( rst_ni                 ),
        .flush_i      ( flush_i                ),
        .flush_ftq_i  ( flush_ftq_i            ),
        .debug_mode_i ( debug_mode_i           ),
        .vpc_i        ( vpc_i                  ),
        .upd_valid_i  ( upd_valid_i            ),
        .upd_pc_i     ( upd_pc_i               ),
        .upd_taken_i  ( upd_taken_i            ),
        .head_idx_i   ( head_idx               ),
        .head_tag_i   ( head_tag               ),
        .head_cnt_i   ( head_cnt               ),
        .head_empty_i ( ftq_empty              ),
        .fetch_idx_o  ( fetch_idx              ),
        .fetch_tag_o  ( fetch_tag              ),
        .pop_o        ( ftq_pop                ),
        .pred_valid_o ( bht_prediction_valid_o ),
        .pred_taken_o ( bht_prediction_taken_o )
    );

endmodule

// ==== tb_bht.sv ====
// ====================
// testbench for the branch history top: random
// fetch and resolve traffic checked against a model
// ====================
`timescale 1ns/1ps

module tb_bht;

    localparam int unsigned RESET_CYCLES    = 8;
    localparam int unsigned RAND_CYCLES     = 300;
    localparam int unsigned DIRECTED_CYCLES = 80;
    localparam int unsigned STIM_CYCLES     = RESET_CYCLES + RAND_CYCLES + DIRECTED_CYCLES;
    localparam int unsigned CYCLE_LIMIT     = STIM_CYCLES * 3 / 2;

    logic                                                     clk_i;
    logic                                                     rst_ni;
    logic                                                     flush_i;
    logic                                                     flush_ftq_i;
    logic                                                     debug_mode_i;
    bp_types_pkg::vaddr_t                                     vpc_i;
    bp_cfg_pkg::slot_mask_t                                   valid_i;
    bp_cfg_pkg::slot_mask_t                                   is_branch_i;
    bp_types_pkg::cf_kind_e [bp_cfg_pkg::INSTR_PER_FETCH-1:0] cf_kind_i;
    logic                                                     instr_queue_overflow_i;
    logic [bp_cfg_pkg::SLOT_BITS-1:0]                         push_instr_cnt_i;
    logic                                                     upd_valid_i;
    bp_types_pkg::vaddr_t                                     upd_pc_i;
    logic                                                     upd_taken_i;
    logic                                                     ftq_overflow_o;
    bp_cfg_pkg::slot_mask_t                                   bht_prediction_valid_o;
    bp_cfg_pkg::slot_mask_t                                   bht_prediction_taken_o;

    // reference model state
    logic [1:0]           m_cnt [bp_cfg_pkg::NR_ROWS][bp_cfg_pkg::INSTR_PER_FETCH];
    bp_cfg_pkg::tag_t     m_tag [bp_cfg_pkg::NR_ROWS][bp_cfg_pkg::INSTR_PER_FETCH];
    bp_cfg_pkg::ghr_t     m_ghr;
    bp_cfg_pkg::row_idx_t m_q_idx [$];
    bp_cfg_pkg::tag_t     m_q_tag [$];
    bp_cfg_pkg::bp_cnt_t  m_q_cnt [$];
    bp_cfg_pkg::bp_cnt_t  m_rem;
    // pc of every recorded branch still waiting for its resolve
    bp_types_pkg::vaddr_t pending_pc [$];

    logic [31:0] seed;
    int unsigned errors;
    int unsigned cycles;

    bht u_bht (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // run limit, independent of the stimulus process
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [15:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[30:15];
    endfunction

    // mostly none, otherwise one of the redirecting kinds
    function automatic bp_types_pkg::cf_kind_e pick_kind(logic [3:0] v);
        if (v < 4'd10) begin
            return bp_types_pkg::CF_NONE;
        end
        return bp_types_pkg::cf_kind_e'(3'(v[1:0]) + 3'd1);
    endfunction

    // row bits 6..2 folded with both 5-bit chunks of the one-padded history
    function automatic bp_cfg_pkg::row_idx_t gshare_index(bp_types_pkg::vaddr_t pc,
                                                          bp_cfg_pkg::ghr_t ghr);
        logic [9:0] padded;
        padded = {2'b11, ghr};
        return pc[6:2] ^ padded[4:0] ^ padded[9:5];
    endfunction

    // replay, then cut off behind the first redirecting slot
    function automatic bp_cfg_pkg::slot_mask_t surviving_branches();
        bp_cfg_pkg::slot_mask_t mask;
        logic ahead;
        logic replayed;
        ahead = 1'b0;
        for (int i = 0; i < bp_cfg_pkg::INSTR_PER_FETCH; i++) begin
            replayed = instr_queue_overflow_i && (i >= push_instr_cnt_i);
            mask[i]  = is_branch_i[i] && !replayed && !ahead;
            if (valid_i[i] && cf_kind_i[i] != bp_types_pkg::CF_NONE) begin
                ahead = 1'b1;
            end
        end
        return mask;
    endfunction

    task automatic clear_queue();
        m_q_idx.delete();
        m_q_tag.delete();
        m_q_cnt.delete();
        pending_pc.delete();
        m_rem = '0;
    endtask

    task automatic report_mismatch(string name, logic [7:0] exp_v, logic [7:0] act_v);
        errors++;
        $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, exp_v, act_v);
    endtask

    // combinational outputs against the model, mid cycle
    task automatic check_outputs();
        bp_cfg_pkg::row_idx_t   idx;
        bp_cfg_pkg::tag_t       tag;
        bp_cfg_pkg::slot_mask_t exp_valid;
        bp_cfg_pkg::slot_mask_t exp_taken;
        logic                   exp_ovf;
        idx = gshare_index(vpc_i, m_ghr);
        tag = vpc_i[14:7];
        for (int i = 0; i < bp_cfg_pkg::INSTR_PER_FETCH; i++) begin
            exp_valid[i] = (m_tag[idx][i] == tag);
            exp_taken[i] = m_cnt[idx][i][1];
        end
        exp_ovf = (|surviving_branches()) && (m_q_idx.size() == bp_cfg_pkg::FTQ_DEPTH);
        if (bht_prediction_valid_o !== exp_valid) begin
            report_mismatch("bht_prediction_valid_o", exp_valid, bht_prediction_valid_o);
        end
        if (bht_prediction_taken_o !== exp_taken) begin
            report_mismatch("bht_prediction_taken_o", exp_taken, bht_prediction_taken_o);
        end
        if (ftq_overflow_o !== exp_ovf) begin
            report_mismatch("ftq_overflow_o", exp_ovf, ftq_overflow_o);
        end
    endtask

    // state change at the rising edge, from the inputs held across it
    task automatic model_clock();
        bp_cfg_pkg::slot_mask_t mask;
        bp_cfg_pkg::bp_cnt_t    cnt;
        bp_cfg_pkg::bp_cnt_t    rem_eff;
        bp_cfg_pkg::row_idx_t   push_idx;
        bp_cfg_pkg::row_idx_t   ridx;
        bp_types_pkg::vaddr_t   br_pc;
        logic                   full;
        logic                   slot;
        logic [1:0]             old;
        mask     = surviving_branches();
        cnt      = '0;
        for (int i = 0; i < bp_cfg_pkg::INSTR_PER_FETCH; i++) begin
            cnt = cnt + mask[i];
        end
        // push data and full flag are taken before this edge changes anything
        push_idx = gshare_index(vpc_i, m_ghr);
        full     = (m_q_idx.size() == bp_cfg_pkg::FTQ_DEPTH);
        if (flush_i) begin
            foreach (m_cnt[r, s]) begin
                m_cnt[r][s] = bp_types_pkg::CNT_WEAK_T;
            end
            m_ghr = '0;
            clear_queue();
        end else begin
            if (upd_valid_i && !debug_mode_i) begin
                ridx = m_q_idx[0];
                slot = upd_pc_i[1];
                old  = m_cnt[ridx][slot];
                if (m_tag[ridx][slot] != m_q_tag[0]) begin
                    m_cnt[ridx][slot] = upd_taken_i ? bp_types_pkg::CNT_WEAK_T
                                                    : bp_types_pkg::CNT_WEAK_NT;
                end else if (upd_taken_i && old != 2'b11) begin
                    m_cnt[ridx][slot] = old + 2'd1;
                end else if (!upd_taken_i && old != 2'b00) begin
                    m_cnt[ridx][slot] = old - 2'd1;
                end
                m_tag[ridx][slot] = m_q_tag[0];
                m_ghr   = {m_ghr[6:0], upd_taken_i};
                rem_eff = (m_rem == '0) ? m_q_cnt[0] : m_rem;
                m_rem   = rem_eff - 1'b1;
                if (rem_eff == 2'd1) begin
                    void'(m_q_idx.pop_front());
                    void'(m_q_tag.pop_front());
                    void'(m_q_cnt.pop_front());
                end
                void'(pending_pc.pop_front());
            end
            if (flush_ftq_i) begin
                clear_queue();
            end else if (cnt != '0 && !full) begin
                m_q_idx.push_back(push_idx);
                m_q_tag.push_back(vpc_i[14:7]);
                m_q_cnt.push_back(cnt);
                for (int i = 0; i < bp_cfg_pkg::INSTR_PER_FETCH; i++) begin
                    br_pc    = vpc_i;
                    br_pc[1] = i[0];
                    if (mask[i]) begin
                        pending_pc.push_back(br_pc);
                    end
                end
            end
        end
    endtask

    task automatic run_cycle();
        @(negedge clk_i);
        check_outputs();
        @(posedge clk_i);
        model_clock();
        #1;
    endtask

    task automatic set_idle();
        flush_i                = 1'b0;
        flush_ftq_i            = 1'b0;
        debug_mode_i           = 1'b0;
        valid_i                = '0;
        is_branch_i            = '0;
        cf_kind_i[0]           = bp_types_pkg::CF_NONE;
        cf_kind_i[1]           = bp_types_pkg::CF_NONE;
        instr_queue_overflow_i = 1'b0;
        push_instr_cnt_i       = '0;
        upd_valid_i            = 1'b0;
        upd_pc_i               = '0;
        upd_taken_i            = 1'b0;
    endtask

    task automatic fetch_block(bp_types_pkg::vaddr_t pc, bp_cfg_pkg::slot_mask_t br);
        set_idle();
        vpc_i       = pc;
        valid_i     = '1;
        is_branch_i = br;
        run_cycle();
    endtask

    task automatic resolve_next(logic taken, logic debug);
        set_idle();
        debug_mode_i = debug;
        upd_valid_i  = 1'b1;
        upd_pc_i     = pending_pc[0];
        upd_taken_i  = taken;
        run_cycle();
    endtask

    task automatic drain_pending();
        logic [15:0] r;
        while (pending_pc.size() != 0) begin
            r = lcg_next();
            resolve_next(r[7], 1'b0);
        end
    endtask

    // small address pool: 8 tags over all rows, so tags hit often
    task automatic random_cycle();
        logic [15:0] r;
        r = lcg_next();
        vpc_i                  = {22'd0, r[10:8], r[4:0], 2'b00};
        r = lcg_next();
        valid_i                = r[1:0];
        is_branch_i            = r[3:2];
        cf_kind_i[0]           = pick_kind(r[7:4]);
        cf_kind_i[1]           = pick_kind(r[11:8]);
        instr_queue_overflow_i = (r[13:12] == 2'b00);
        push_instr_cnt_i       = r[14];
        r = lcg_next();
        upd_valid_i            = (pending_pc.size() != 0) && r[0];
        upd_pc_i               = upd_valid_i ? pending_pc[0] : {16'd0, r};
        upd_taken_i            = r[1];
        debug_mode_i           = (r[5:2] == 4'd0);
        flush_i                = (r[11:6] == 6'd0);
        flush_ftq_i            = (r[15:10] == 6'd1);
        run_cycle();
    endtask

    initial begin
        seed   = 32'h627b;
        errors = 0;
        cycles = 0;
        rst_ni = 1'b0;
        vpc_i  = '0;
        set_idle();
        foreach (m_cnt[r, s]) begin
            m_cnt[r][s] = '0;
            m_tag[r][s] = '0;
        end
        m_ghr = '0;
        clear_queue();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // reset state, no pushes
        for (int i = 0; i < 4; i++) begin
            set_idle();
            vpc_i = {16'd0, lcg_next()} << 2;
            run_cycle();
        end

        // mixed fetch, replay, redirect, resolve, flush and debug traffic
        for (int i = 0; i < RAND_CYCLES; i++) begin
            random_cycle();
        end
        drain_pending();

        // same block before and after different outcomes lands in other rows
        set_idle();
        flush_i = 1'b1;
        run_cycle();
        fetch_block(32'h0000_1a40, 2'b01);
        resolve_next(1'b1, 1'b0);
        fetch_block(32'h0000_1a40, 2'b01);
        resolve_next(1'b0, 1'b0);
        fetch_block(32'h0000_1a40, 2'b01);
        resolve_next(1'b1, 1'b0);

        // fifth block with no resolves overflows and is lost
        set_idle();
        flush_ftq_i = 1'b1;
        run_cycle();
        for (int b = 0; b < 5; b++) begin
            fetch_block(32'h0000_2000 + (b << 7), 2'b11);
        end
        drain_pending();

        // full flush makes every tag match predict taken
        set_idle();
        flush_i = 1'b1;
        run_cycle();
        for (int i = 0; i < 8; i++) begin
            set_idle();
            vpc_i = {22'd0, 10'(lcg_next())} << 2;
            run_cycle();
        end

        // resolves under debug mode are ignored and the entry stays queued
        fetch_block(32'h0000_1a40, 2'b11);
        resolve_next(1'b0, 1'b1);
        resolve_next(1'b0, 1'b1);
        drain_pending();

        // queue flush alone drops the pending block, table keeps its state
        fetch_block(32'h0000_3300, 2'b10);
        set_idle();
        flush_ftq_i = 1'b1;
        run_cycle();
        fetch_block(32'h0000_3380, 2'b01);
        drain_pending();
        set_idle();
        vpc_i = 32'h0000_3380;
        run_cycle();

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
bp_cfg_pkg.sv
bp_types_pkg.sv
branch_filter.sv
ftq_fifo.sv
bht_table.sv
bht.sv
tb_bht.sv
